// File: mem_scheduler.f
+incdir+bench
hw/mem_sched_pkg.sv
hw/x_tile_cfg_if.sv
hw/x_tile_walker.sv
hw/dequant_bias_unit.sv
hw/mem_scheduler.sv
bench/tb_mem_scheduler.sv

// File: Makefile
TOP := tb_mem_scheduler

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f mem_scheduler.f --top-module mem_scheduler

sim:
	verilator --binary --timing -f mem_scheduler.f --top-module $(TOP) -o sim_$(TOP)
	out=$$(./obj_dir/sim_$(TOP)); echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

// File: bench/tb_checks.svh
// Compare tasks, per-test reporting and check counters for the memory scheduler testbench
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int chk_cnt       = 0;
int err_cnt       = 0;
int test_cnt      = 0;
int test_err_base = 0;

task automatic check_addr(input string name, input addr_t got, input addr_t exp);
  chk_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("ERR %0t %s got 0x%08h exp 0x%08h", $time, name, got, exp);
  end
endtask

task automatic check_len(input string name, input len_t got, input len_t exp);
  chk_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("ERR %0t %s got %0d exp %0d", $time, name, got, exp);
  end
endtask

task automatic check_bias(input string name, input logic [31:0] got,
                          input logic [31:0] exp);
  chk_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("ERR %0t %s got 0x%08h exp 0x%08h", $time, name, got, exp);
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  chk_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("ERR %0t %s got %b exp %b", $time, name, got, exp);
  end
endtask

task automatic begin_test();
  test_err_base = err_cnt;
endtask

// One line per finished test
task automatic end_test(input string name);
  test_cnt++;
  if (err_cnt == test_err_base) begin
    $display("[ok]   %s", name);
  end else begin
    $display("[bad]  %s, %0d errors", name, err_cnt - test_err_base);
  end
endtask

task automatic report_counts();
  $display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
endtask

`endif

// File: bench/tb_mem_scheduler.sv
// Testbench top for the memory scheduler with clock, reset, stimulus tables and test loops
`timescale 1ns/1ps
`default_nettype none

module tb_mem_scheduler
  import mem_sched_pkg::*;
();

  localparam int unsigned LenW = $clog2(ARRAY_W) + 1;
  localparam int ReqTimeout = 16;
  localparam int NumWalk    = 4;
  localparam int NumFixed   = 5;
  localparam int NumBias    = 13;

  typedef logic [LenW-1:0] len_t;
  typedef logic [GROUP_W:0] gidx_t;

  typedef struct {
    addr_t x_addr;
    iter_t cols;
    iter_t ws;
    iter_t rows;
    addr_t row_offs;
    len_t  last_rows;
  } walk_cfg_t;

  typedef struct {
    qint_fmt_e   fmt;
    logic [15:0] stride;
    gidx_t       gidx;
    logic [15:0] row;
    logic [31:0] scales;
    logic [31:0] zeros;
    logic [31:0] wq;
    logic        skip;
  } bias_vec_t;

  logic clk_i, rst_ni, clear_i, start_i, idle_i, x_ready_start_i, x_done_i;
  addr_t x_addr_i, row_offs_i;
  iter_t col_iters_i, w_iters_i, row_iters_i, tot_reads_i;
  len_t last_rows_i;
  logic x_req_start_o;
  addr_t x_base_addr_o;
  len_t x_tot_len_o;
  qint_fmt_e qint_fmt_i;
  logic [15:0] w_stride_i, row_data_i;
  gidx_t gidx_data_i;
  logic gidx_valid_i, gidx_ready_o, bias_ready_i, bias_valid_o, skip_o;
  logic row_valid_i, row_ready_o, wq_bias_ready_i, wq_bias_valid_o;
  logic [31:0] scales_bias_o, zeros_bias_o, wq_bias_o;

  walk_cfg_t walk_tbl [NumWalk];
  bias_vec_t bias_tbl [NumBias];
  addr_t exp_addr_q [$];
  len_t exp_len_q [$];
  integer seed;

  `include "tb_checks.svh"

  mem_scheduler #(
    .ArrayW ( ARRAY_W ),
    .GroupW ( GROUP_W )
  ) dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic next_cycle();
    @(posedge clk_i);
    #2;
  endtask

  task automatic apply_cfg(input int i);
    x_addr_i    = walk_tbl[i].x_addr;
    col_iters_i = walk_tbl[i].cols;
    w_iters_i   = walk_tbl[i].ws;
    row_iters_i = walk_tbl[i].rows;
    row_offs_i  = walk_tbl[i].row_offs;
    last_rows_i = walk_tbl[i].last_rows;
    tot_reads_i = walk_tbl[i].cols * walk_tbl[i].ws * walk_tbl[i].rows;
  endtask

  task automatic clear_walk();
    clear_i = 1'b1;
    next_cycle();
    clear_i = 1'b0;
  endtask

  task automatic pulse_done();
    next_cycle();
    start_i  = 1'b0;
    x_done_i = 1'b1;
    next_cycle();
    x_done_i = 1'b0;
  endtask

  task automatic wait_for_req(output bit seen);
    int waited;
    waited = 0;
    #1;
    while (x_req_start_o !== 1'b1 && waited < ReqTimeout) begin
      next_cycle();
      #1;
      waited++;
    end
    seen = (x_req_start_o === 1'b1);
    if (!seen) begin
      err_cnt++;
      $display("Timeout at %0t: no X read request within %0d cycles", $time, ReqTimeout);
    end
  endtask

  // Expected walk order with columns innermost, then W iterations, then rows
  task automatic build_walk(input int i);
    int unsigned r, w, c, n_rows, n_ws, n_cols;
    n_rows = 32'(walk_tbl[i].rows);
    n_ws   = 32'(walk_tbl[i].ws);
    n_cols = 32'(walk_tbl[i].cols);
    exp_addr_q.delete();
    exp_len_q.delete();
    for (r = 0; r < n_rows; r++) begin
      for (w = 0; w < n_ws; w++) begin
        for (c = 0; c < n_cols; c++) begin
          exp_addr_q.push_back(walk_tbl[i].x_addr + r * walk_tbl[i].row_offs + c * COL_JMP);
          if (r == n_rows - 1 && walk_tbl[i].last_rows != '0) begin
            exp_len_q.push_back(walk_tbl[i].last_rows);
          end else begin
            exp_len_q.push_back(len_t'(ARRAY_W));
          end
        end
      end
    end
  endtask

  function automatic logic [15:0] narrow_stride(qint_fmt_e fmt, logic [15:0] stride);
    case (fmt)
      QINT_2:  return stride >> 3;
      QINT_4:  return stride >> 2;
      default: return stride >> 1;
    endcase
  endfunction

  task automatic fill_tables();
    int unsigned sel;
    logic [15:0] narrow;
    walk_tbl[0] = '{32'h0000_1000, 16'd2, 16'd1, 16'd2, 32'h0000_0200, 3'd0};
    walk_tbl[1] = '{32'h0000_8000, 16'd3, 16'd2, 16'd2, 32'h0000_0400, 3'd3};
    walk_tbl[2] = '{32'h0000_0040, 16'd1, 16'd3, 16'd3, 32'h0000_0100, 3'd1};
    walk_tbl[3] = '{32'h000A_0000, 16'd4, 16'd1, 16'd1, 32'h0000_0000, 3'd2};
    // Hand-checked corner values
    // Top index bit is the skip flag
    bias_tbl[0] = '{QINT_8, 16'd100, 9'h003, 16'd5, 32'd300, 32'd150, 32'd250, 1'b0};
    bias_tbl[1] = '{QINT_4, 16'd256, 9'h10A, 16'd7, 32'd2560, 32'd640, 32'd448, 1'b1};
    bias_tbl[2] = '{QINT_2, 16'd1000, 9'h0FF, 16'd1000, 32'd255000, 32'd31875,
                    32'd125000, 1'b0};
    bias_tbl[3] = '{QINT_8, 16'hFFFF, 9'h1FF, 16'hFFFF, 32'd16711425, 32'd8355585,
                    32'd2147385345, 1'b1};
    bias_tbl[4] = '{QINT_4, 16'd7, 9'h002, 16'd9, 32'd14, 32'd2, 32'd9, 1'b0};
    for (int i = NumFixed; i < NumBias; i++) begin
      sel = $unsigned($random(seed)) % 3;
      bias_tbl[i].fmt    = qint_fmt_e'(2'(sel));
      bias_tbl[i].stride = 16'($random(seed));
      bias_tbl[i].gidx   = gidx_t'($random(seed));
      bias_tbl[i].row    = 16'($random(seed));
      narrow = narrow_stride(bias_tbl[i].fmt, bias_tbl[i].stride);
      bias_tbl[i].scales = 32'(bias_tbl[i].gidx[GROUP_W-1:0]) * 32'(bias_tbl[i].stride);
      bias_tbl[i].zeros  = 32'(bias_tbl[i].gidx[GROUP_W-1:0]) * 32'(narrow);
      bias_tbl[i].wq     = 32'(bias_tbl[i].row) * 32'(narrow);
      bias_tbl[i].skip   = bias_tbl[i].gidx[GROUP_W];
    end
  endtask

  task automatic reset_state();
    begin_test();
    build_walk(3);
    next_cycle();
    #1;
    check_bit("x_req_start_o", x_req_start_o, 1'b0);
    check_addr("x_base_addr_o", x_base_addr_o, exp_addr_q[0]);
    check_len("x_tot_len_o", x_tot_len_o, exp_len_q[0]);
    end_test("state after reset");
  endtask

  task automatic walk_addresses(input int i);
    bit seen;
    int n;
    seen = 1'b0;
    begin_test();
    next_cycle();
    apply_cfg(i);
    build_walk(i);
    n = exp_addr_q.size();
    idle_i = 1'b0;
    x_ready_start_i = 1'b1;
    clear_walk();
    #1;
    check_bit("x_req_start_o", x_req_start_o, 1'b0);
    next_cycle();
    start_i = 1'b1;
    for (int k = 0; k < n; k++) begin
      wait_for_req(seen);
      if (!seen) break;
      check_addr("x_base_addr_o", x_base_addr_o, exp_addr_q[k]);
      check_len("x_tot_len_o", x_tot_len_o, exp_len_q[k]);
      pulse_done();
    end
    // All loops wrapped after the last read
    if (seen) begin
      #1;
      check_bit("x_req_start_o", x_req_start_o, 1'b0);
      check_addr("x_base_addr_o", x_base_addr_o, walk_tbl[i].x_addr);
    end
    end_test($sformatf("address walk, config %0d", i));
  endtask

  task automatic request_rule();
    int counts [5] = '{0, 1, 3, 4, 5};
    int done_cnt, tot;
    logic idle_v, start_v, ready_v, exp_req;
    begin_test();
    next_cycle();
    apply_cfg(0);
    tot = int'(tot_reads_i);
    clear_walk();
    done_cnt = 0;
    for (int j = 0; j < 5; j++) begin
      while (done_cnt < counts[j]) begin
        pulse_done();
        done_cnt++;
      end
      for (int combo = 0; combo < 8; combo++) begin
        idle_v  = combo[0];
        start_v = combo[1];
        ready_v = combo[2];
        exp_req = !idle_v && ready_v && (start_v || (done_cnt != 0 && done_cnt != tot));
        idle_i = idle_v;
        start_i = start_v;
        x_ready_start_i = ready_v;
        #1;
        check_bit("x_req_start_o", x_req_start_o, exp_req);
        next_cycle();
      end
    end
    idle_i = 1'b0;
    start_i = 1'b0;
    x_ready_start_i = 1'b1;
    end_test("request rule");
  endtask

  task automatic bias_values();
    begin_test();
    for (int i = 0; i < NumBias; i++) begin
      next_cycle();
      qint_fmt_i = bias_tbl[i].fmt;
      w_stride_i = bias_tbl[i].stride;
      gidx_data_i = bias_tbl[i].gidx;
      row_data_i = bias_tbl[i].row;
      gidx_valid_i = 1'b1;
      row_valid_i = 1'b1;
      bias_ready_i = 1'b1;
      wq_bias_ready_i = 1'b1;
      #1;
      check_bias("scales_bias_o", scales_bias_o, bias_tbl[i].scales);
      check_bias("zeros_bias_o", zeros_bias_o, bias_tbl[i].zeros);
      check_bias("wq_bias_o", wq_bias_o, bias_tbl[i].wq);
      check_bit("skip_o", skip_o, bias_tbl[i].skip);
    end
    end_test("bias values");
  endtask

  task automatic backpressure();
    logic b_rdy, wq_rdy, g_vld, r_vld;
    begin_test();
    for (int i = 0; i < NumBias; i++) begin
      for (int combo = 0; combo < 16; combo++) begin
        next_cycle();
        b_rdy  = combo[0];
        wq_rdy = combo[1];
        g_vld  = combo[2];
        r_vld  = combo[3];
        gidx_data_i = bias_tbl[i].gidx;
        row_data_i = bias_tbl[i].row;
        gidx_valid_i = g_vld;
        row_valid_i = r_vld;
        bias_ready_i = b_rdy;
        wq_bias_ready_i = wq_rdy;
        #1;
        check_bit("bias_valid_o", bias_valid_o, g_vld && b_rdy);
        check_bit("gidx_ready_o", gidx_ready_o, b_rdy);
        check_bit("wq_bias_valid_o", wq_bias_valid_o, r_vld && wq_rdy);
        check_bit("row_ready_o", row_ready_o, wq_rdy);
      end
    end
    end_test("bias back-pressure");
  endtask

  task automatic clear_mid_walk();
    begin_test();
    next_cycle();
    apply_cfg(1);
    build_walk(1);
    idle_i = 1'b0;
    x_ready_start_i = 1'b1;
    clear_walk();
    for (int k = 0; k < 5; k++) begin
      pulse_done();
    end
    #1;
    check_addr("x_base_addr_o", x_base_addr_o, exp_addr_q[5]);
    next_cycle();
    clear_i = 1'b1;
    next_cycle();
    clear_i = 1'b0;
    #1;
    check_addr("x_base_addr_o", x_base_addr_o, walk_tbl[1].x_addr);
    check_len("x_tot_len_o", x_tot_len_o, exp_len_q[0]);
    check_bit("x_req_start_o", x_req_start_o, 1'b0);
    pulse_done();
    pulse_done();
    // Clear wins over a done pulse in the same cycle
    next_cycle();
    clear_i = 1'b1;
    x_done_i = 1'b1;
    next_cycle();
    clear_i = 1'b0;
    x_done_i = 1'b0;
    #1;
    check_addr("x_base_addr_o", x_base_addr_o, walk_tbl[1].x_addr);
    end_test("clear in mid-walk");
  endtask

  initial begin
    seed = 88;
    rst_ni = 1'b0;
    clear_i = 1'b0;
    start_i = 1'b0;
    idle_i = 1'b0;
    x_ready_start_i = 1'b1;
    x_done_i = 1'b0;
    qint_fmt_i = QINT_8;
    w_stride_i = '0;
    gidx_valid_i = 1'b0;
    gidx_data_i = '0;
    bias_ready_i = 1'b0;
    row_valid_i = 1'b0;
    row_data_i = '0;
    wq_bias_ready_i = 1'b0;
    fill_tables();
    apply_cfg(3);
    repeat (10) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    reset_state();
    for (int i = 0; i < NumWalk; i++) begin
      walk_addresses(i);
    end
    request_rule();
    bias_values();
    backpressure();
    clear_mid_walk();
    report_counts();
    if (err_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule : tb_mem_scheduler

`default_nettype wire

// File: hw/mem_scheduler.sv
// Memory scheduler top: X-tile walker with its configuration bundle and the bias unit
`timescale 1ns/1ps
`default_nettype none

module mem_scheduler
  import mem_sched_pkg::*;
#(
  parameter int unsigned ArrayW = ARRAY_W,
  parameter int unsigned GroupW = GROUP_W
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  input  logic                    start_i,
  input  logic                    idle_i,
  input  logic                    x_ready_start_i,
  input  logic                    x_done_i,
  // Walker configuration
  input  addr_t                   x_addr_i,
  input  iter_t                   col_iters_i,
  input  iter_t                   w_iters_i,
  input  iter_t                   row_iters_i,
  input  addr_t                   row_offs_i,
  input  iter_t                   tot_reads_i,
  input  logic [$clog2(ArrayW):0] last_rows_i,
  // X read descriptor
  output logic                    x_req_start_o,
  output addr_t                   x_base_addr_o,
  output logic [$clog2(ArrayW):0] x_tot_len_o,
  // Bias streams
  input  qint_fmt_e               qint_fmt_i,
  input  logic [15:0]             w_stride_i,
  input  logic                    gidx_valid_i,
  input  logic [GroupW:0]         gidx_data_i,
  output logic                    gidx_ready_o,
  input  logic                    bias_ready_i,
  output logic                    bias_valid_o,
  output logic [31:0]             scales_bias_o,
  output logic [31:0]             zeros_bias_o,
  output logic                    skip_o,
  input  logic                    row_valid_i,
  input  logic [15:0]             row_data_i,
  output logic                    row_ready_o,
  input  logic                    wq_bias_ready_i,
  output logic                    wq_bias_valid_o,
  output logic [31:0]             wq_bias_o
);

  x_tile_cfg_if #(
    .ArrayW ( ArrayW )
  ) x_cfg ();

  assign x_cfg.x_addr    = x_addr_i;
  assign x_cfg.col_iters = col_iters_i;
  assign x_cfg.w_iters   = w_iters_i;
  assign x_cfg.row_iters = row_iters_i;
  assign x_cfg.row_offs  = row_offs_i;
  assign x_cfg.tot_reads = tot_reads_i;
  assign x_cfg.last_rows = last_rows_i;
  // Registers are always loaded at this level
  assign x_cfg.cfg_valid = 1'b1;

  x_tile_walker #(
    .ArrayW ( ArrayW )
  ) i_x_tile_walker (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .clear_i         ( clear_i         ),
    .start_i         ( start_i         ),
    .idle_i          ( idle_i          ),
    .x_ready_start_i ( x_ready_start_i ),
    .x_done_i        ( x_done_i        ),
    .cfg             ( x_cfg.cfg_dst   ),
    .x_req_start_o   ( x_req_start_o   ),
    .x_base_addr_o   ( x_base_addr_o   ),
    .x_tot_len_o     ( x_tot_len_o     )
  );

  dequant_bias_unit #(
    .GroupW ( GroupW )
  ) i_dequant_bias_unit (
    .qint_fmt_i      ( qint_fmt_i      ),
    .w_stride_i      ( w_stride_i      ),
    .gidx_valid_i    ( gidx_valid_i    ),
    .gidx_data_i     ( gidx_data_i     ),
    .gidx_ready_o    ( gidx_ready_o    ),
    .bias_ready_i    ( bias_ready_i    ),
    .bias_valid_o    ( bias_valid_o    ),
    .scales_bias_o   ( scales_bias_o   ),
    .zeros_bias_o    ( zeros_bias_o    ),
    .skip_o          ( skip_o          ),
    .row_valid_i     ( row_valid_i     ),
    .row_data_i      ( row_data_i      ),
    .row_ready_o     ( row_ready_o     ),
    .wq_bias_ready_i ( wq_bias_ready_i ),
    .wq_bias_valid_o ( wq_bias_valid_o ),
    .wq_bias_o       ( wq_bias_o       )
  );

endmodule : mem_scheduler

`default_nettype wire

// File: hw/dequant_bias_unit.sv
// Dequantization bias unit: scale, zero-point and quantized-weight offsets from index streams
`timescale 1ns/1ps
`default_nettype none

module dequant_bias_unit
  import mem_sched_pkg::*;
#(
  parameter int unsigned GroupW = GROUP_W
) (
  input  qint_fmt_e         qint_fmt_i,
  input  logic [15:0]       w_stride_i,
  input  logic              gidx_valid_i,
  input  logic [GroupW:0]   gidx_data_i,
  output logic              gidx_ready_o,
  input  logic              bias_ready_i,
  output logic              bias_valid_o,
  output logic [31:0]       scales_bias_o,
  output logic [31:0]       zeros_bias_o,
  output logic              skip_o,
  input  logic              row_valid_i,
  input  logic [15:0]       row_data_i,
  output logic              row_ready_o,
  input  logic              wq_bias_ready_i,
  output logic              wq_bias_valid_o,
  output logic [31:0]       wq_bias_o
);

  logic [1:0]        q_shift;
  logic [15:0]       stride_narrow;
  logic [GroupW-1:0] gidx;

  // Packed weights shrink the stride by the number of elements per byte
  always_comb begin
    case (qint_fmt_i)
      QINT_2:  q_shift = 2'd3;
      QINT_4:  q_shift = 2'd2;
      default: q_shift = 2'd1;
    endcase
  end

  assign stride_narrow = w_stride_i >> q_shift;

  // Top bit of the index is the skip flag
  assign gidx   = gidx_data_i[GroupW-1:0];
  assign skip_o = gidx_data_i[GroupW];

  assign gidx_ready_o = bias_ready_i;
  assign bias_valid_o = gidx_valid_i && bias_ready_i;

  assign scales_bias_o = 32'(gidx) * 32'(w_stride_i);
  assign zeros_bias_o  = 32'(gidx) * 32'(stride_narrow);

  // Row stream
  assign row_ready_o     = wq_bias_ready_i;
  assign wq_bias_valid_o = row_valid_i && wq_bias_ready_i;
  assign wq_bias_o       = 32'(row_data_i) * 32'(stride_narrow);

endmodule : dequant_bias_unit

`default_nettype wire

// File: hw/x_tile_walker.sv
// X-tile walker: nested loop counters, address offsets, read descriptor and read request
`timescale 1ns/1ps
`default_nettype none

module x_tile_walker
  import mem_sched_pkg::*;
#(
  parameter int unsigned ArrayW = ARRAY_W
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  input  logic                    start_i,
  input  logic                    idle_i,
  input  logic                    x_ready_start_i,
  input  logic                    x_done_i,
  x_tile_cfg_if.cfg_dst           cfg,
  output logic                    x_req_start_o,
  output addr_t                   x_base_addr_o,
  output logic [$clog2(ArrayW):0] x_tot_len_o
);

  localparam int unsigned LenW = $clog2(ArrayW) + 1;

  iter_t col_cnt_d, col_cnt_q;
  iter_t w_cnt_d, w_cnt_q;
  iter_t row_cnt_d, row_cnt_q;
  iter_t read_cnt_q;

  addr_t col_offs_d, col_offs_q;
  addr_t row_offs_d, row_offs_q;

  iter_t col_max, w_max, row_max;
  logic  col_last, w_last, row_last;
  logic  row_step;

  // Last index of each loop
  assign col_max = cfg.col_iters - 16'd1;
  assign w_max   = cfg.w_iters - 16'd1;
  assign row_max = cfg.row_iters - 16'd1;

  assign col_last = (col_cnt_q == col_max);
  assign w_last   = (w_cnt_q == w_max);
  assign row_last = (row_cnt_q == row_max);

  // Row tile moves on only after every W iteration over all columns
  assign row_step = col_last && w_last;

  assign col_cnt_d = col_last ? '0 : col_cnt_q + 16'd1;
  assign w_cnt_d   = w_last ? '0 : w_cnt_q + 16'd1;
  assign row_cnt_d = row_last ? '0 : row_cnt_q + 16'd1;

  assign col_offs_d = col_last ? '0 : col_offs_q + COL_JMP;
  assign row_offs_d = row_last ? '0 : row_offs_q + cfg.row_offs;

  always_ff @(posedge clk_i or negedge rst_ni) begin : loop_counters
    if (!rst_ni) begin
      col_cnt_q  <= '0;
      w_cnt_q    <= '0;
      row_cnt_q  <= '0;
      read_cnt_q <= '0;
    end else if (clear_i) begin
      col_cnt_q  <= '0;
      w_cnt_q    <= '0;
      row_cnt_q  <= '0;
      read_cnt_q <= '0;
    end else if (x_done_i) begin
      col_cnt_q  <= col_cnt_d;
      read_cnt_q <= read_cnt_q + 16'd1;
      if (col_last) begin
        w_cnt_q <= w_cnt_d;
      end
      if (row_step) begin
        row_cnt_q <= row_cnt_d;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : addr_offsets
    if (!rst_ni) begin
      col_offs_q <= '0;
      row_offs_q <= '0;
    end else if (clear_i) begin
      col_offs_q <= '0;
      row_offs_q <= '0;
    end else if (x_done_i) begin
      col_offs_q <= col_offs_d;
      if (row_step) begin
        row_offs_q <= row_offs_d;
      end
    end
  end

  assign x_base_addr_o = cfg.x_addr + row_offs_q + col_offs_q;

  // Partial tile only on the last row tile
  assign x_tot_len_o = (row_last && (cfg.last_rows != '0)) ? cfg.last_rows
                                                           : LenW'(ArrayW);

  // First read on start, later reads until the total is reached
  assign x_req_start_o = cfg.cfg_valid && !idle_i && x_ready_start_i &&
                         (start_i || ((read_cnt_q != '0) && (read_cnt_q != cfg.tot_reads)));

endmodule : x_tile_walker

`default_nettype wire

// File: hw/x_tile_cfg_if.sv
// X-tile loop configuration bundle with source and destination modports
`timescale 1ns/1ps
`default_nettype none

interface x_tile_cfg_if
  import mem_sched_pkg::*;
#(
  parameter int unsigned ArrayW = ARRAY_W
);

  addr_t                 x_addr;
  iter_t                 col_iters;
  iter_t                 w_iters;
  iter_t                 row_iters;
  addr_t                 row_offs;
  iter_t                 tot_reads;
  // Leftover rows of the last row tile, 0 for a full tile
  logic [$clog2(ArrayW):0] last_rows;
  logic                  cfg_valid;

  modport cfg_src (
    output x_addr, col_iters, w_iters, row_iters, row_offs, tot_reads, last_rows, cfg_valid
  );

  modport cfg_dst (
    input  x_addr, col_iters, w_iters, row_iters, row_offs, tot_reads, last_rows, cfg_valid
  );

endinterface : x_tile_cfg_if

`default_nettype wire

// File: hw/mem_sched_pkg.sv
// Shared widths, quantized weight format and X column step of the memory scheduler
`default_nettype none

package mem_sched_pkg;

  // Byte address on the memory side
  typedef logic [31:0] addr_t;

  // Loop counts and limits of the X walk
  typedef logic [15:0] iter_t;

  // Quantized weight format, encoding matches the dequant mode register field
  typedef enum logic [1:0] {
    QINT_8 = 2'd0,
    QINT_4 = 2'd1,
    QINT_2 = 2'd2
  } qint_fmt_e;

  // Byte step between adjacent X column tiles
  localparam addr_t COL_JMP = 32'd64;

  // Rows in a full X tile
  localparam int unsigned ARRAY_W = 4;

  // Width of a group index, without the skip flag
  localparam int unsigned GROUP_W = 8;

endpackage : mem_sched_pkg

`default_nettype wire
